// ==== all.f ====
rt_pkg.sv
scene_bounds_regs.sv
slab_pipe.sv
sint_fifo.sv
scene_int.sv
rt_scene_top.sv
tb_scene_int.sv

// ==== rt_pkg.sv ====
// integer coordinates only; the shader supplies nonzero reciprocal directions
package rt_pkg;

	// scene coordinate or box bound
	typedef logic signed [15:0] coord_t;

	// reciprocal direction component from the shader
	typedef logic signed [15:0] inv_t;

	// bound minus origin, one bit wider than a coordinate
	typedef logic signed [16:0] diff_t;

	// full product of a diff_t and an inv_t
	typedef logic signed [32:0] t_t;

	typedef logic [8:0] ray_id_t;

	typedef logic [2:0] cfg_addr_t;

	// slab test depth, strobe in to result out
	localparam int SLAB_LATENCY = 4;

	// entries per output queue
	localparam int QUEUE_DEPTH = 16;

	// free slots, 0 to QUEUE_DEPTH
	typedef logic [4:0] free_t;

	// bound register map
	localparam cfg_addr_t CFG_XMIN = 3'd0;
	localparam cfg_addr_t CFG_XMAX = 3'd1;
	localparam cfg_addr_t CFG_YMIN = 3'd2;
	localparam cfg_addr_t CFG_YMAX = 3'd3;
	localparam cfg_addr_t CFG_ZMIN = 3'd4;
	localparam cfg_addr_t CFG_ZMAX = 3'd5;

	// queue word widths
	// tarb word is {ray_id, is_shadow, t_min, t_max}
	localparam int TARB_W = $bits(ray_id_t) + 1 + 2 * $bits(t_t);

	// ss word is {ray_id, t_max}
	localparam int SS_W = $bits(ray_id_t) + $bits(t_t);

	// shader word is the ray_id alone
	localparam int SH_W = $bits(ray_id_t);

endpackage

// ==== rt_scene_top.sv ====
// scene box must be written before rays are sent; latencies are those of scene_int
`timescale 1ns/1ps

module rt_scene_top (
	input  logic              clk,
	input  logic              rst,
	input  logic              cfg_we,
	input  rt_pkg::cfg_addr_t cfg_addr,
	input  rt_pkg::coord_t    cfg_wdata,
	input  logic              shader_to_sint_valid,
	input  rt_pkg::ray_id_t   ray_id,
	input  logic              is_shadow,
	input  rt_pkg::coord_t    origin_x,
	input  rt_pkg::coord_t    origin_y,
	input  rt_pkg::coord_t    origin_z,
	input  rt_pkg::inv_t      inv_x,
	input  rt_pkg::inv_t      inv_y,
	input  rt_pkg::inv_t      inv_z,
	output logic              shader_to_sint_stall,
	output logic              sint_to_tarb_valid,
	output rt_pkg::ray_id_t   tarb_ray_id,
	output logic              tarb_is_shadow,
	output rt_pkg::t_t        tarb_t_min,
	output rt_pkg::t_t        tarb_t_max,
	input  logic              sint_to_tarb_stall,
	input  logic              sint_to_ss_stall,
	input  logic              sint_to_shader_stall,
	output logic              sint_to_ss_valid,
	output rt_pkg::ray_id_t   ss_ray_id,
	output rt_pkg::t_t        ss_t_max,
	output logic              sint_to_shader_valid,
	output rt_pkg::ray_id_t   shader_ray_id
);

	rt_pkg::coord_t xmin, xmax, ymin, ymax, zmin, zmax;

	scene_bounds_regs bounds_i (
		.clk      (clk),
		.rst      (rst),
		.cfg_we   (cfg_we),
		.cfg_addr (cfg_addr),
		.cfg_wdata(cfg_wdata),
		.xmin     (xmin),
		.xmax     (xmax),
		.ymin     (ymin),
		.ymax     (ymax),
		.zmin     (zmin),
		.zmax     (zmax)
	);

	// scene intersector, fed by the bound registers
	scene_int sint_i (
		.clk                 (clk),
		.rst                 (rst),
		.xmin                (xmin),
		.xmax                (xmax),
		.ymin                (ymin),
		.ymax                (ymax),
		.zmin                (zmin),
		.zmax                (zmax),
		.shader_to_sint_valid(shader_to_sint_valid),
		.ray_id              (ray_id),
		.is_shadow           (is_shadow),
		.origin_x            (origin_x),
		.origin_y            (origin_y),
		.origin_z            (origin_z),
		.inv_x               (inv_x),
		.inv_y               (inv_y),
		.inv_z               (inv_z),
		.shader_to_sint_stall(shader_to_sint_stall),
		.sint_to_tarb_valid  (sint_to_tarb_valid),
		.tarb_ray_id         (tarb_ray_id),
		.tarb_is_shadow      (tarb_is_shadow),
		.tarb_t_min          (tarb_t_min),
		.tarb_t_max          (tarb_t_max),
		.sint_to_tarb_stall  (sint_to_tarb_stall),
		.sint_to_ss_stall    (sint_to_ss_stall),
		.sint_to_shader_stall(sint_to_shader_stall),
		.sint_to_ss_valid    (sint_to_ss_valid),
		.ss_ray_id           (ss_ray_id),
		.ss_t_max            (ss_t_max),
		.sint_to_shader_valid(sint_to_shader_valid),
		.shader_ray_id       (shader_ray_id)
	);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# builds and runs the scene intersection testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_scene_int -o sim_tb
./obj_dir/sim_tb > sim.log
cat sim.log

if grep -qx "all tests passed" sim.log; then
	exit 0
else
	exit 1
fi

// ==== scene_bounds_regs.sv ====
// bounds are cleared by reset; rewriting them with rays in flight is not supported
`timescale 1ns/1ps

module scene_bounds_regs (
	input  logic              clk,
	input  logic              rst,
	input  logic              cfg_we,
	input  rt_pkg::cfg_addr_t cfg_addr,
	input  rt_pkg::coord_t    cfg_wdata,
	output rt_pkg::coord_t    xmin,
	output rt_pkg::coord_t    xmax,
	output rt_pkg::coord_t    ymin,
	output rt_pkg::coord_t    ymax,
	output rt_pkg::coord_t    zmin,
	output rt_pkg::coord_t    zmax
);

	import rt_pkg::*;

	always_ff @(posedge clk) begin
		if (rst) begin
			xmin <= '0;
			xmax <= '0;
			ymin <= '0;
			ymax <= '0;
			zmin <= '0;
			zmax <= '0;
		end else if (cfg_we) begin
			// one bound per write strobe
			case (cfg_addr)
				CFG_XMIN: xmin <= cfg_wdata;
				CFG_XMAX: xmax <= cfg_wdata;
				CFG_YMIN: ymin <= cfg_wdata;
				CFG_YMAX: ymax <= cfg_wdata;
				CFG_ZMIN: zmin <= cfg_wdata;
				CFG_ZMAX: zmax <= cfg_wdata;
				default: ;
			endcase
		end
	end

	// addresses 6 and 7 are unmapped
	a_cfg_addr_range: assert property (
		@(posedge clk) disable iff (rst)
		cfg_we |-> (cfg_addr <= CFG_ZMAX)
	) else $error("config write to unmapped address %0d", cfg_addr);

endmodule

// ==== scene_int.sv ====
// never stalls internally; input stall reserves a queue slot for every ray in flight
`timescale 1ns/1ps

module scene_int (
	input  logic            clk,
	input  logic            rst,
	input  rt_pkg::coord_t  xmin,
	input  rt_pkg::coord_t  xmax,
	input  rt_pkg::coord_t  ymin,
	input  rt_pkg::coord_t  ymax,
	input  rt_pkg::coord_t  zmin,
	input  rt_pkg::coord_t  zmax,
	input  logic            shader_to_sint_valid,
	input  rt_pkg::ray_id_t ray_id,
	input  logic            is_shadow,
	input  rt_pkg::coord_t  origin_x,
	input  rt_pkg::coord_t  origin_y,
	input  rt_pkg::coord_t  origin_z,
	input  rt_pkg::inv_t    inv_x,
	input  rt_pkg::inv_t    inv_y,
	input  rt_pkg::inv_t    inv_z,
	output logic            shader_to_sint_stall,
	output logic            sint_to_tarb_valid,
	output rt_pkg::ray_id_t tarb_ray_id,
	output logic            tarb_is_shadow,
	output rt_pkg::t_t      tarb_t_min,
	output rt_pkg::t_t      tarb_t_max,
	input  logic            sint_to_tarb_stall,
	input  logic            sint_to_ss_stall,
	input  logic            sint_to_shader_stall,
	output logic            sint_to_ss_valid,
	output rt_pkg::ray_id_t ss_ray_id,
	output rt_pkg::t_t      ss_t_max,
	output logic            sint_to_shader_valid,
	output rt_pkg::ray_id_t shader_ray_id
);

	import rt_pkg::*;

	localparam int IF_W = $clog2(SLAB_LATENCY + 1);

	logic accept;
	logic cap_valid;
	ray_id_t cap_id;
	logic cap_shadow;
	coord_t cap_ox, cap_oy, cap_oz;
	inv_t cap_ix, cap_iy, cap_iz;

	// id and shadow flag ride beside the slab pipe
	ray_id_t id_pipe [SLAB_LATENCY];
	logic shadow_pipe [SLAB_LATENCY];

	logic slab_valid, slab_miss;
	t_t slab_t_min, slab_t_max;
	logic hit_we, miss_we;
	logic [IF_W-1:0] in_flight;
	free_t tarb_free, ss_free, sh_free, min_free;
	logic tarb_empty, ss_empty, sh_empty;
	logic [TARB_W-1:0] tarb_word;
	logic [SS_W-1:0] ss_word;
	logic [SH_W-1:0] sh_word;

	assign accept = shader_to_sint_valid && !shader_to_sint_stall;

	always_ff @(posedge clk) begin
		if (rst)
			cap_valid <= 1'b0;
		else
			cap_valid <= accept;
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			cap_id     <= ray_id;
			cap_shadow <= is_shadow;
			cap_ox     <= origin_x;
			cap_oy     <= origin_y;
			cap_oz     <= origin_z;
			cap_ix     <= inv_x;
			cap_iy     <= inv_y;
			cap_iz     <= inv_z;
		end
	end

	always_ff @(posedge clk) begin
		id_pipe[0]     <= cap_id;
		shadow_pipe[0] <= cap_shadow;
		for (int i = 1; i < SLAB_LATENCY; i++) begin
			id_pipe[i]     <= id_pipe[i-1];
			shadow_pipe[i] <= shadow_pipe[i-1];
		end
	end

	slab_pipe slab_i (
		.clk      (clk),
		.rst      (rst),
		.in_valid (cap_valid),
		.origin_x (cap_ox),
		.origin_y (cap_oy),
		.origin_z (cap_oz),
		.inv_x    (cap_ix),
		.inv_y    (cap_iy),
		.inv_z    (cap_iz),
		.xmin     (xmin),
		.xmax     (xmax),
		.ymin     (ymin),
		.ymax     (ymax),
		.zmin     (zmin),
		.zmax     (zmax),
		.out_valid(slab_valid),
		.t_min    (slab_t_min),
		.t_max    (slab_t_max),
		.miss     (slab_miss)
	);

	// hits feed tarb and ss together, misses go back to the shader
	assign hit_we  = slab_valid && !slab_miss;
	assign miss_we = slab_valid && slab_miss;

	// rays inside the slab pipe, entered from capture and left by queue write
	always_ff @(posedge clk) begin
		if (rst)
			in_flight <= '0;
		else
			in_flight <= in_flight + IF_W'(cap_valid) - IF_W'(slab_valid);
	end

	always_comb begin
		min_free = tarb_free;
		if (ss_free < min_free)
			min_free = ss_free;
		if (sh_free < min_free)
			min_free = sh_free;
	end

	// capture stage counts as one more ray on its way in
	assign shader_to_sint_stall = (min_free <= free_t'(in_flight) + free_t'(cap_valid));

	sint_fifo #(.WIDTH(TARB_W), .DEPTH(QUEUE_DEPTH)) tarb_q (
		.clk  (clk),
		.rst  (rst),
		.we   (hit_we),
		.wdata({id_pipe[SLAB_LATENCY-1], shadow_pipe[SLAB_LATENCY-1], slab_t_min, slab_t_max}),
		.re   (sint_to_tarb_valid && !sint_to_tarb_stall),
		.rdata(tarb_word),
		.empty(tarb_empty),
		.free (tarb_free)
	);

	sint_fifo #(.WIDTH(SS_W), .DEPTH(QUEUE_DEPTH)) ss_q (
		.clk  (clk),
		.rst  (rst),
		.we   (hit_we),
		.wdata({id_pipe[SLAB_LATENCY-1], slab_t_max}),
		.re   (sint_to_ss_valid && !sint_to_ss_stall),
		.rdata(ss_word),
		.empty(ss_empty),
		.free (ss_free)
	);

	sint_fifo #(.WIDTH(SH_W), .DEPTH(QUEUE_DEPTH)) sh_q (
		.clk  (clk),
		.rst  (rst),
		.we   (miss_we),
		.wdata(id_pipe[SLAB_LATENCY-1]),
		.re   (sint_to_shader_valid && !sint_to_shader_stall),
		.rdata(sh_word),
		.empty(sh_empty),
		.free (sh_free)
	);

	assign sint_to_tarb_valid = !tarb_empty;
	assign {tarb_ray_id, tarb_is_shadow, tarb_t_min, tarb_t_max} = tarb_word;
	assign sint_to_ss_valid = !ss_empty;
	assign {ss_ray_id, ss_t_max} = ss_word;
	assign sint_to_shader_valid = !sh_empty;
	assign shader_ray_id = sh_word;

	a_in_flight_bound: assert property (
		@(posedge clk) disable iff (rst)
		in_flight <= IF_W'(SLAB_LATENCY)
	) else $error("in-flight count %0d above slab depth", in_flight);

endmodule

// ==== scene_stim.txt ====
# C addr value | R id shadow ox oy oz ix iy iz | P name sink_mode
# sink_mode 0 idle sinks, 1 sinks held until released, 2 random sink stalls
P basic 0
C 0 -100
C 1 100
C 2 -100
C 3 100
C 4 -50
C 5 50
R 1 0 0 0 0 3 -2 5
R 2 1 -300 10 0 4 1 1
R 3 0 200 0 0 2 2 2
R 4 1 -10 20 5 -7 3 -1
P hold 1
R 10 0 0 0 0 1 1 1
R 11 0 5 -5 3 2 1 -1
R 12 1 -20 30 10 1 -3 2
R 13 0 40 -40 -20 -1 2 1
R 14 0 -90 90 45 3 3 3
R 15 1 15 -60 0 -2 -1 4
R 16 0 70 10 -30 1 5 -2
R 17 0 -70 -10 30 -4 1 1
R 18 1 0 99 -49 2 -2 2
R 19 0 99 0 49 -1 -1 -1
R 20 0 -50 -50 0 6 1 -3
R 21 1 50 50 0 1 -6 3
R 22 0 25 -75 12 -5 2 2
R 23 0 -25 75 -12 2 -5 1
R 24 1 60 -20 40 1 1 -7
R 25 0 -60 20 -40 -3 4 1
R 26 0 8 8 8 9 -9 9
R 27 1 -8 -8 -8 -9 9 -9
P random 2
R 30 0 0 0 0 1 2 3
R 31 1 300 0 0 1 1 1
R 32 1 -20 -20 10 -2 3 1
R 33 0 0 -250 0 1 -1 1
R 34 0 -150 0 0 5 1 1
R 35 1 30 40 -45 1 -1 2
R 36 0 0 0 120 1 1 2
R 37 1 -99 99 0 4 -4 4
P rebox 0
C 0 0
C 1 400
R 40 0 200 0 0 2 2 2
R 41 1 -50 0 0 -1 1 1
R 42 0 350 -90 40 -3 2 1
R 43 1 450 0 0 1 1 1

// ==== sint_fifo.sv ====
// DEPTH must be a power of two no larger than QUEUE_DEPTH; rdata is valid only when not empty
`timescale 1ns/1ps

module sint_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = rt_pkg::QUEUE_DEPTH
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              we,
	input  logic [WIDTH-1:0]  wdata,
	input  logic              re,
	output logic [WIDTH-1:0]  rdata,
	output logic              empty,
	output rt_pkg::free_t     free
);

	import rt_pkg::*;

	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	// storage has no reset
	always_ff @(posedge clk) begin
		if (we)
			mem[wr_ptr] <= wdata;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			// pointers wrap on their own width
			if (we)
				wr_ptr <= wr_ptr + 1'b1;
			if (re)
				rd_ptr <= rd_ptr + 1'b1;
			if (we && !re)
				count <= count + 1'b1;
			else if (re && !we)
				count <= count - 1'b1;
		end
	end

	// head word, held until it is read
	assign rdata = mem[rd_ptr];
	assign empty = (count == '0);
	assign free  = free_t'(DEPTH) - free_t'(count);

	a_no_overflow: assert property (
		@(posedge clk) disable iff (rst)
		we |-> (count != CNT_W'(DEPTH))
	) else $error("write into full queue");

	a_no_underflow: assert property (
		@(posedge clk) disable iff (rst)
		re |-> !empty
	) else $error("read from empty queue");

endmodule

// ==== slab_pipe.sv ====
// fixed four-cycle slab test with no stall; t_min is clamped at zero
`timescale 1ns/1ps

module slab_pipe (
	input  logic           clk,
	input  logic           rst,
	input  logic           in_valid,
	input  rt_pkg::coord_t origin_x,
	input  rt_pkg::coord_t origin_y,
	input  rt_pkg::coord_t origin_z,
	input  rt_pkg::inv_t   inv_x,
	input  rt_pkg::inv_t   inv_y,
	input  rt_pkg::inv_t   inv_z,
	input  rt_pkg::coord_t xmin,
	input  rt_pkg::coord_t xmax,
	input  rt_pkg::coord_t ymin,
	input  rt_pkg::coord_t ymax,
	input  rt_pkg::coord_t zmin,
	input  rt_pkg::coord_t zmax,
	output logic           out_valid,
	output rt_pkg::t_t     t_min,
	output rt_pkg::t_t     t_max,
	output logic           miss
);

	import rt_pkg::*;

	// stage valids
	logic v1, v2, v3;

	// stage 1 offsets and carried reciprocals
	diff_t dx_lo, dx_hi, dy_lo, dy_hi, dz_lo, dz_hi;
	inv_t  s1_inv_x, s1_inv_y, s1_inv_z;

	// stage 2 plane distances
	t_t ta_x, tb_x, ta_y, tb_y, ta_z, tb_z;

	// stage 3 per-axis entry and exit
	t_t ent_x, ext_x, ent_y, ext_y, ent_z, ext_z;

	// stage 4 reduction, combinational
	t_t enter_max, exit_min;

	always_ff @(posedge clk) begin
		if (rst) begin
			v1        <= 1'b0;
			v2        <= 1'b0;
			v3        <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			v1        <= in_valid;
			v2        <= v1;
			v3        <= v2;
			out_valid <= v3;
		end
	end

	// stage 1, sign-extended subtract
	always_ff @(posedge clk) begin
		dx_lo    <= diff_t'(xmin) - diff_t'(origin_x);
		dx_hi    <= diff_t'(xmax) - diff_t'(origin_x);
		dy_lo    <= diff_t'(ymin) - diff_t'(origin_y);
		dy_hi    <= diff_t'(ymax) - diff_t'(origin_y);
		dz_lo    <= diff_t'(zmin) - diff_t'(origin_z);
		dz_hi    <= diff_t'(zmax) - diff_t'(origin_z);
		s1_inv_x <= inv_x;
		s1_inv_y <= inv_y;
		s1_inv_z <= inv_z;
	end

	// stage 2, 17x16 signed multiplies into 33 bits
	always_ff @(posedge clk) begin
		ta_x <= t_t'(dx_lo) * t_t'(s1_inv_x);
		tb_x <= t_t'(dx_hi) * t_t'(s1_inv_x);
		ta_y <= t_t'(dy_lo) * t_t'(s1_inv_y);
		tb_y <= t_t'(dy_hi) * t_t'(s1_inv_y);
		ta_z <= t_t'(dz_lo) * t_t'(s1_inv_z);
		tb_z <= t_t'(dz_hi) * t_t'(s1_inv_z);
	end

	// stage 3, a negative reciprocal swaps the planes
	always_ff @(posedge clk) begin
		ent_x <= (ta_x < tb_x) ? ta_x : tb_x;
		ext_x <= (ta_x < tb_x) ? tb_x : ta_x;
		ent_y <= (ta_y < tb_y) ? ta_y : tb_y;
		ext_y <= (ta_y < tb_y) ? tb_y : ta_y;
		ent_z <= (ta_z < tb_z) ? ta_z : tb_z;
		ext_z <= (ta_z < tb_z) ? tb_z : ta_z;
	end

	always_comb begin
		// entry can never be behind the origin
		enter_max = '0;
		if (ent_x > enter_max)
			enter_max = ent_x;
		if (ent_y > enter_max)
			enter_max = ent_y;
		if (ent_z > enter_max)
			enter_max = ent_z;
		exit_min = ext_x;
		if (ext_y < exit_min)
			exit_min = ext_y;
		if (ext_z < exit_min)
			exit_min = ext_z;
	end

	// stage 4 result registers
	always_ff @(posedge clk) begin
		t_min <= enter_max;
		t_max <= exit_min;
		miss  <= (enter_max > exit_min);
	end

endmodule

// ==== tb_scene_int.sv ====
// reads scene_stim.txt from the working directory; expects the simulator to run in the project root
`timescale 1ns/1ps

module tb_scene_int;

	import rt_pkg::*;

	typedef int fields_t [8];

	logic clk;
	logic rst;
	logic cfg_we;
	cfg_addr_t cfg_addr;
	coord_t cfg_wdata;
	logic shader_to_sint_valid;
	ray_id_t ray_id;
	logic is_shadow;
	coord_t origin_x, origin_y, origin_z;
	inv_t inv_x, inv_y, inv_z;
	logic shader_to_sint_stall;
	logic sint_to_tarb_valid;
	ray_id_t tarb_ray_id;
	logic tarb_is_shadow;
	t_t tarb_t_min, tarb_t_max;
	logic sint_to_tarb_stall, sint_to_ss_stall, sint_to_shader_stall;
	logic sint_to_ss_valid;
	ray_id_t ss_ray_id;
	t_t ss_t_max;
	logic sint_to_shader_valid;
	ray_id_t shader_ray_id;

	// parsed stimulus lines
	byte kinds[$];
	fields_t vals[$];
	string names[$];
	int n_rays;

	// expected output streams
	ray_id_t exp_tarb_id[$];
	logic exp_tarb_sh[$];
	t_t exp_tarb_min[$];
	t_t exp_tarb_max[$];
	ray_id_t exp_ss_id[$];
	t_t exp_ss_max[$];
	ray_id_t exp_sh_id[$];

	// scene box as the model sees it
	int bnd[6];

	string test_name;
	int mode;
	logic released;
	int total_acc;
	int phase_base;
	int last_acc;
	int cycle;
	int limit;
	logic [31:0] lfsr_state;
	logic prev_tarb, prev_ss, prev_sh;
	int err_tarb, err_ss, err_sh, err_lat, err_other;

	rt_scene_top dut_i (
		.clk                 (clk),
		.rst                 (rst),
		.cfg_we              (cfg_we),
		.cfg_addr            (cfg_addr),
		.cfg_wdata           (cfg_wdata),
		.shader_to_sint_valid(shader_to_sint_valid),
		.ray_id              (ray_id),
		.is_shadow           (is_shadow),
		.origin_x            (origin_x),
		.origin_y            (origin_y),
		.origin_z            (origin_z),
		.inv_x               (inv_x),
		.inv_y               (inv_y),
		.inv_z               (inv_z),
		.shader_to_sint_stall(shader_to_sint_stall),
		.sint_to_tarb_valid  (sint_to_tarb_valid),
		.tarb_ray_id         (tarb_ray_id),
		.tarb_is_shadow      (tarb_is_shadow),
		.tarb_t_min          (tarb_t_min),
		.tarb_t_max          (tarb_t_max),
		.sint_to_tarb_stall  (sint_to_tarb_stall),
		.sint_to_ss_stall    (sint_to_ss_stall),
		.sint_to_shader_stall(sint_to_shader_stall),
		.sint_to_ss_valid    (sint_to_ss_valid),
		.ss_ray_id           (ss_ray_id),
		.ss_t_max            (ss_t_max),
		.sint_to_shader_valid(sint_to_shader_valid),
		.shader_ray_id       (shader_ray_id)
	);

	always #20 clk = ~clk;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic next_stall_bit(output logic b);
		lfsr_state = lfsr_step(lfsr_state);
		b = lfsr_state[0];
	endtask

	// slab rule on the model's own copy of the box
	task automatic model_ray(input int id, input logic sh, input int o[3], input int iv[3]);
		longint ta, tb, en, ex, tmin, tmax;
		tmin = 0;
		tmax = 64'sh7fff_ffff_ffff;
		for (int a = 0; a < 3; a++) begin
			ta = longint'(bnd[2*a] - o[a]) * longint'(iv[a]);
			tb = longint'(bnd[2*a+1] - o[a]) * longint'(iv[a]);
			en = (ta < tb) ? ta : tb;
			ex = (ta < tb) ? tb : ta;
			if (en > tmin)
				tmin = en;
			if (ex < tmax)
				tmax = ex;
		end
		if (tmin > tmax) begin
			exp_sh_id.push_back(ray_id_t'(id));
		end else begin
			exp_tarb_id.push_back(ray_id_t'(id));
			exp_tarb_sh.push_back(sh);
			exp_tarb_min.push_back(t_t'(tmin));
			exp_tarb_max.push_back(t_t'(tmax));
			exp_ss_id.push_back(ray_id_t'(id));
			exp_ss_max.push_back(t_t'(tmax));
		end
	endtask

	task automatic check_tarb(input ray_id_t id, input logic sh, input t_t tmin, input t_t tmax);
		ray_id_t e_id;
		logic e_sh;
		t_t e_min, e_max;
		if (exp_tarb_id.size() == 0) begin
			err_tarb++;
			$display("%s: tarb queue sent ray %0d that was never expected", test_name, id);
		end else begin
			e_id = exp_tarb_id.pop_front();
			e_sh = exp_tarb_sh.pop_front();
			e_min = exp_tarb_min.pop_front();
			e_max = exp_tarb_max.pop_front();
			if (id !== e_id || sh !== e_sh || tmin !== e_min || tmax !== e_max) begin
				err_tarb++;
				// fields in order id, shadow, t_min, t_max
				$display("Mismatch %s tarb: expected %0d %0d %0d %0d actual %0d %0d %0d %0d",
					test_name, e_id, e_sh, e_min, e_max, id, sh, tmin, tmax);
			end
		end
	endtask

	task automatic check_ss(input ray_id_t id, input t_t tmax);
		ray_id_t e_id;
		t_t e_max;
		if (exp_ss_id.size() == 0) begin
			err_ss++;
			$display("%s: ss queue sent ray %0d that was never expected", test_name, id);
		end else begin
			e_id = exp_ss_id.pop_front();
			e_max = exp_ss_max.pop_front();
			if (id !== e_id || tmax !== e_max) begin
				err_ss++;
				$display("Mismatch %s ss: expected id %0d t_max %0d actual id %0d t_max %0d",
					test_name, e_id, e_max, id, tmax);
			end
		end
	endtask

	task automatic check_shader(input ray_id_t id);
		ray_id_t e_id;
		if (exp_sh_id.size() == 0) begin
			err_sh++;
			$display("%s: shader queue sent ray %0d that was never expected", test_name, id);
		end else begin
			e_id = exp_sh_id.pop_front();
			if (id !== e_id) begin
				err_sh++;
				$display("Mismatch %s shader: expected id %0d actual id %0d", test_name, e_id, id);
			end
		end
	endtask

	task automatic check_latency(input string q, input int edges);
		if (edges != 5) begin
			err_lat++;
			$display("Mismatch %s %s latency: expected 5 actual %0d", test_name, q, edges);
		end
	endtask

	// sampling before the edge, so DUT and driver values are settled
	always @(posedge clk) begin
		logic b0, b1, b2;
		int o[3];
		int iv[3];
		cycle++;
		if (cycle >= limit) begin
			$display("timeout after %0d cycles", cycle);
			$display("tests failed");
			$finish;
		end else begin
			if (!rst) begin
				if (cfg_we && cfg_addr <= 3'd5)
					bnd[cfg_addr] = int'(cfg_wdata);
				if (shader_to_sint_valid && !shader_to_sint_stall) begin
					o = '{int'(origin_x), int'(origin_y), int'(origin_z)};
					iv = '{int'(inv_x), int'(inv_y), int'(inv_z)};
					model_ray(int'(ray_id), is_shadow, o, iv);
					total_acc <= total_acc + 1;
					last_acc <= cycle;
				end
				// valid first seen one edge after it rises
				if (mode == 0) begin
					if (sint_to_tarb_valid && !prev_tarb)
						check_latency("tarb", cycle - last_acc - 1);
					if (sint_to_ss_valid && !prev_ss)
						check_latency("ss", cycle - last_acc - 1);
					if (sint_to_shader_valid && !prev_sh)
						check_latency("shader", cycle - last_acc - 1);
				end
				if (sint_to_tarb_valid && !sint_to_tarb_stall)
					check_tarb(tarb_ray_id, tarb_is_shadow, tarb_t_min, tarb_t_max);
				if (sint_to_ss_valid && !sint_to_ss_stall)
					check_ss(ss_ray_id, ss_t_max);
				if (sint_to_shader_valid && !sint_to_shader_stall)
					check_shader(shader_ray_id);
			end
			prev_tarb <= sint_to_tarb_valid;
			prev_ss <= sint_to_ss_valid;
			prev_sh <= sint_to_shader_valid;
			if (mode == 2) begin
				next_stall_bit(b0);
				next_stall_bit(b1);
				next_stall_bit(b2);
			end else begin
				b0 = (mode == 1) && !released;
				b1 = b0;
				b2 = b0;
			end
			sint_to_tarb_stall <= b0;
			sint_to_ss_stall <= b1;
			sint_to_shader_stall <= b2;
		end
	end

	task automatic read_stim();
		int fd, n;
		string line, nm;
		byte k;
		int v[8];
		fd = $fopen("scene_stim.txt", "r");
		if (fd == 0) begin
			err_other++;
			$display("cannot open scene_stim.txt");
		end else begin
			while ($fgets(line, fd) != 0) begin
				n = 0;
				v = '{default: 0};
				nm = "";
				k = (line.len() > 0) ? line.getc(0) : 8'h23;
				case (k)
					"C": n = $sscanf(line, "C %d %d", v[0], v[1]);
					"R": n = $sscanf(line, "R %d %d %d %d %d %d %d %d",
						v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
					"P": n = $sscanf(line, "P %s %d", nm, v[0]);
					default: n = 0;
				endcase
				if (n > 0) begin
					kinds.push_back(k);
					vals.push_back(v);
					names.push_back(nm);
					if (k == "R")
						n_rays++;
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic write_cfg(input int a, input int v);
		cfg_we <= 1'b1;
		cfg_addr <= cfg_addr_t'(a);
		cfg_wdata <= coord_t'(v);
		@(posedge clk);
		cfg_we <= 1'b0;
		@(posedge clk);
	endtask

	task automatic send_ray(input fields_t f);
		int waits;
		waits = 0;
		ray_id <= ray_id_t'(f[0]);
		is_shadow <= (f[1] != 0);
		origin_x <= coord_t'(f[2]);
		origin_y <= coord_t'(f[3]);
		origin_z <= coord_t'(f[4]);
		inv_x <= inv_t'(f[5]);
		inv_y <= inv_t'(f[6]);
		inv_z <= inv_t'(f[7]);
		shader_to_sint_valid <= 1'b1;
		@(posedge clk);
		while (shader_to_sint_stall) begin
			waits++;
			// input stall has held long enough, queues must be full
			if (mode == 1 && !released && waits == 30) begin
				if (total_acc - phase_base != QUEUE_DEPTH) begin
					err_other++;
					$display("Mismatch %s accepted before stall: expected %0d actual %0d",
						test_name, QUEUE_DEPTH, total_acc - phase_base);
				end
				released <= 1'b1;
			end
			@(posedge clk);
		end
		shader_to_sint_valid <= 1'b0;
	endtask

	task automatic drain_queues();
		int waited;
		waited = 0;
		// one edge so a ray accepted on the current edge is in the model
		@(posedge clk);
		while ((exp_tarb_id.size() != 0 || exp_ss_id.size() != 0 || exp_sh_id.size() != 0)
			&& waited < 8 * QUEUE_DEPTH) begin
			waited++;
			@(posedge clk);
		end
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		cfg_we = 1'b0;
		cfg_addr = '0;
		cfg_wdata = '0;
		shader_to_sint_valid = 1'b0;
		ray_id = '0;
		is_shadow = 1'b0;
		origin_x = '0;
		origin_y = '0;
		origin_z = '0;
		inv_x = 16'sd1;
		inv_y = 16'sd1;
		inv_z = 16'sd1;
		sint_to_tarb_stall = 1'b0;
		sint_to_ss_stall = 1'b0;
		sint_to_shader_stall = 1'b0;
		bnd = '{default: 0};
		test_name = "reset";
		mode = 0;
		released = 1'b0;
		lfsr_state = 32'h17b0_224f;
		limit = 1000000;
		read_stim();
		limit = 200 + 40 * n_rays;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		repeat (4) begin
			@(posedge clk);
			if (sint_to_tarb_valid || sint_to_ss_valid || sint_to_shader_valid
				|| shader_to_sint_stall) begin
				err_other++;
				$display("an output valid or the input stall is high after reset");
			end
		end
		for (int i = 0; i < kinds.size(); i++) begin
			case (kinds[i])
				"P": begin
					drain_queues();
					test_name = names[i];
					mode <= vals[i][0];
					released <= 1'b0;
					phase_base <= total_acc;
					@(posedge clk);
				end
				"C": write_cfg(vals[i][0], vals[i][1]);
				default: begin
					send_ray(vals[i]);
					// one ray at a time keeps the latency check exact
					if (mode == 0)
						drain_queues();
				end
			endcase
		end
		drain_queues();
		repeat (10) @(posedge clk);
		if (exp_tarb_id.size() + exp_ss_id.size() + exp_sh_id.size() != 0) begin
			err_other++;
			$display("expected output words never arrived");
		end
		$display("errors tarb %0d ss %0d shader %0d latency %0d other %0d",
			err_tarb, err_ss, err_sh, err_lat, err_other);
		if (err_tarb + err_ss + err_sh + err_lat + err_other == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule
